//--- conv_stream.f
+incdir+verilog
verilog/conv_stream_pkg.sv
verilog/stream_sequencer.sv
verilog/layer_geometry.sv
verilog/weight_distributor.sv
verilog/pixel_emitter.sv
verilog/conv_stream.sv
bench/tb_clock.sv
bench/conv_stream_tb.sv

//--- bench/conv_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_stream_config.svh"

module conv_stream_tb;

    // beats of all seven jobs, plus cycles per job for cache and ack waits
    localparam int JOB_BEATS  = 253;
    localparam int JOBS       = 7;
    localparam int TIMEOUT_NS = (JOB_BEATS * 4 + JOBS * 40 + 200) * 20;

    logic clk;
    logic reset;
    conv_stream_pkg::stream_word_u r_data;
    logic r_valid;
    logic r_last;
    logic r_ready;
    conv_stream_pkg::layer_cfg_t   layer_cfg;
    conv_stream_pkg::geometry_t    geometry;
    conv_stream_pkg::norm_params_t norm_params;
    logic [`CS_WORD_WIDTH-1:0] weights;
    logic [`CS_OUTPUT_DIM-1:0] channel_sel;
    logic [`CS_WORD_WIDTH-1:0] pixels;
    logic pixels_valid;
    logic pixels_last;
    logic cache_wrt_done;
    logic save_result_valid;
    logic save_result_ack;
    logic cache_blk_sel;
    logic accum_valid;

    integer seed = 77782;
    int     errors = 0;
    int     checks = 0;
    string  test_name;

    // cache block the model expects, zero after reset
    logic   blk_sel_model = 1'b0;

    // observed outputs
    logic [`CS_WORD_WIDTH-1:0] pix_q[$];
    logic                      last_q[$];
    logic                      rdy_q[$];
    logic [`CS_WORD_WIDTH-1:0] w_q[$];
    logic [`CS_OUTPUT_DIM-1:0] sel_q[$];

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    conv_stream i_conv_stream (
        .clk               (clk),
        .reset             (reset),
        .r_data            (r_data),
        .r_valid           (r_valid),
        .r_last            (r_last),
        .r_ready           (r_ready),
        .layer_cfg         (layer_cfg),
        .geometry          (geometry),
        .norm_params       (norm_params),
        .weights           (weights),
        .channel_sel       (channel_sel),
        .pixels            (pixels),
        .pixels_valid      (pixels_valid),
        .pixels_last       (pixels_last),
        .cache_wrt_done    (cache_wrt_done),
        .save_result_valid (save_result_valid),
        .save_result_ack   (save_result_ack),
        .cache_blk_sel     (cache_blk_sel),
        .accum_valid       (accum_valid)
    );

    // sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!reset && pixels_valid) begin
            pix_q.push_back(pixels);
            last_q.push_back(pixels_last);
            rdy_q.push_back(r_ready);
        end
        if (!reset && channel_sel != '0) begin
            w_q.push_back(weights);
            sel_q.push_back(channel_sel);
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_cfg(input conv_stream_pkg::layer_cfg_t exp,
                             input conv_stream_pkg::layer_cfg_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s, layer_cfg expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_geometry(input conv_stream_pkg::geometry_t exp,
                                  input conv_stream_pkg::geometry_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s, geometry expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_norm(input conv_stream_pkg::norm_params_t exp,
                              input conv_stream_pkg::norm_params_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s, norm_params expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_word(input string what, input logic [`CS_WORD_WIDTH-1:0] exp,
                              input logic [`CS_WORD_WIDTH-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s, %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error: %s, %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("Error: %s, %s count expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic conv_stream_pkg::header_t make_header(
        input logic [`CS_DIM_WIDTH-1:0] cols, input logic [`CS_DIM_WIDTH-1:0] rows,
        input logic [1:0] conv, input logic [3:0] pad, input logic save);
        conv_stream_pkg::header_t h;
        h               = '0;
        // reserved bits set to show they are ignored
        h.reserved      = '1;
        h.cols          = cols;
        h.rows          = rows;
        h.conv_size     = conv;
        h.pad_mask      = pad;
        h.pool_stride   = cols[1:0];
        h.save_result   = save;
        h.activation_en = ~save;
        return h;
    endfunction

    function automatic conv_stream_pkg::layer_cfg_t cfg_of(input conv_stream_pkg::header_t h);
        conv_stream_pkg::layer_cfg_t c;
        c.cols          = h.cols;
        c.rows          = h.rows;
        c.conv_size     = h.conv_size;
        c.pool_stride   = h.pool_stride;
        c.pad_mask      = h.pad_mask;
        c.activation_en = h.activation_en;
        return c;
    endfunction

    // pad bits: 3 right, 2 left, 1 bottom, 0 top
    function automatic conv_stream_pkg::geometry_t geom_of(input conv_stream_pkg::header_t h);
        conv_stream_pkg::geometry_t g;
        int shrink;
        shrink        = (h.conv_size == `CS_CONV_SIZE_3_3) ? 2 : 0;
        g.kernel_dim  = (h.conv_size == `CS_CONV_SIZE_3_3) ? 9 : 1;
        g.result_cols = h.cols + h.pad_mask[2] + h.pad_mask[3] - shrink;
        g.result_rows = h.rows + h.pad_mask[0] + h.pad_mask[1] - shrink;
        return g;
    endfunction

    function automatic logic [`CS_WORD_WIDTH-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic send_beat(input logic [`CS_WORD_WIDTH-1:0] data, input logic last,
                             input int max_gap);
        int   gap;
        logic accepted;
        gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        r_data.data = data;
        r_valid     = 1'b1;
        r_last      = last;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = r_ready;
            @(posedge clk);
            #1;
        end
        r_valid = 1'b0;
        r_last  = 1'b0;
    endtask

    task automatic finish_job(input logic save);
        int   wait_cycles;
        wait_cycles = 3 + $unsigned($random(seed)) % 6;
        repeat (wait_cycles) begin
            @(negedge clk);
            check_bit("r_ready before cache_wrt_done", 1'b0, r_ready);
            check_bit("cache_blk_sel before cache_wrt_done", blk_sel_model, cache_blk_sel);
        end
        @(posedge clk);
        #1 cache_wrt_done = 1'b1;
        @(posedge clk);
        #1 cache_wrt_done = 1'b0;
        // a saved job hands the other cache block to the result path
        if (save) begin
            blk_sel_model = ~blk_sel_model;
        end
        check_bit("r_ready after cache_wrt_done", !save, r_ready);
        check_bit("accum_valid", !save, accum_valid);
        check_bit("save_result_valid", save, save_result_valid);
        check_bit("cache_blk_sel", blk_sel_model, cache_blk_sel);
        if (save) begin
            wait_cycles = $unsigned($random(seed)) % 8;
            repeat (wait_cycles) begin
                @(posedge clk);
                #1 check_bit("save_result_valid before ack", 1'b1, save_result_valid);
            end
            save_result_ack = 1'b1;
            @(posedge clk);
            #1 save_result_ack = 1'b0;
            check_bit("save_result_valid after ack", 1'b0, save_result_valid);
            check_bit("accum_valid after ack", 1'b0, accum_valid);
            check_bit("r_ready after ack", 1'b1, r_ready);
        end
    endtask

    // one full layer job, checked against the model
    task automatic run_job(input conv_stream_pkg::header_t hdr, input int n_pix,
                           input int max_gap);
        conv_stream_pkg::stream_word_u word;
        conv_stream_pkg::norm_params_t norm;
        conv_stream_pkg::geometry_t    geom;
        logic [`CS_WORD_WIDTH-1:0]     exp_w[$];
        logic [`CS_WORD_WIDTH-1:0]     exp_p[$];
        int n_pad;
        int total;
        geom  = geom_of(hdr);
        n_pad = (hdr.pad_mask[1] ? hdr.cols : 0) + (hdr.pad_mask[3] ? 1 : 0);
        total = n_pix + n_pad;
        pix_q.delete();
        last_q.delete();
        rdy_q.delete();
        w_q.delete();
        sel_q.delete();
        word.header = hdr;
        send_beat(word.data, 1'b0, max_gap);
        check_cfg(cfg_of(hdr), layer_cfg);
        if (hdr.save_result) begin
            norm.norm_a = random_word();
            norm.norm_b = random_word();
            send_beat(norm.norm_a, 1'b0, max_gap);
            send_beat(norm.norm_b, 1'b0, max_gap);
            check_norm(norm, norm_params);
        end
        for (int i = 0; i < `CS_OUTPUT_DIM * geom.kernel_dim; i++) begin
            exp_w.push_back(random_word());
            send_beat(exp_w[i], 1'b0, max_gap);
        end
        check_geometry(geom, geometry);
        for (int i = 0; i < n_pix; i++) begin
            exp_p.push_back(random_word());
            send_beat(exp_p[i], i == n_pix - 1, max_gap);
        end
        do begin
            @(negedge clk);
        end while (!(pixels_valid && pixels_last));
        @(posedge clk);
        #1;
        check_count("weight", exp_w.size(), w_q.size());
        for (int i = 0; i < w_q.size() && i < exp_w.size(); i++) begin
            check_word("weights", exp_w[i], w_q[i]);
            check_word("channel_sel", 1 << (i / geom.kernel_dim), sel_q[i]);
        end
        check_count("pixel", total, pix_q.size());
        for (int i = 0; i < pix_q.size() && i < total; i++) begin
            check_word("pixels", (i < n_pix) ? exp_p[i] : {`CS_WORD_WIDTH{1'b0}}, pix_q[i]);
            check_bit("pixels_last", i == total - 1, last_q[i]);
            if (i >= n_pix) begin
                check_bit("r_ready during padding", 1'b0, rdy_q[i]);
            end
        end
        finish_job(hdr.save_result);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_header_decode();
        test_name = "header_decode";
        run_job(make_header(9'd5, 9'd4, `CS_CONV_SIZE_3_3, 4'b1111, 1'b0), 20, 0);
    endtask

    task automatic test_weights();
        test_name = "weights_1x1";
        run_job(make_header(9'd4, 9'd2, `CS_CONV_SIZE_1_1, 4'b0000, 1'b1), 8, 0);
        test_name = "weights_3x3";
        run_job(make_header(9'd4, 9'd2, `CS_CONV_SIZE_3_3, 4'b0000, 1'b1), 8, 1);
    endtask

    task automatic test_pixel_gaps();
        test_name = "pixel_gaps";
        run_job(make_header(9'd8, 9'd5, `CS_CONV_SIZE_1_1, 4'b0000, 1'b0), 40, 3);
    endtask

    task automatic test_padding();
        test_name = "padding";
        run_job(make_header(9'd6, 9'd3, `CS_CONV_SIZE_1_1, 4'b1010, 1'b0), 18, 1);
    endtask

    task automatic test_job_save();
        test_name = "job_save";
        run_job(make_header(9'd4, 9'd3, `CS_CONV_SIZE_3_3, 4'b0000, 1'b1), 12, 1);
    endtask

    task automatic test_job_no_save();
        test_name = "job_no_save";
        run_job(make_header(9'd5, 9'd2, `CS_CONV_SIZE_1_1, 4'b0000, 1'b0), 10, 0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the DUT stopped responding before all tests ended");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        r_data          = '0;
        r_valid         = 1'b0;
        r_last          = 1'b0;
        cache_wrt_done  = 1'b0;
        save_result_ack = 1'b0;
        test_name       = "reset";
        @(negedge clk);
        check_bit("r_ready", 1'b0, r_ready);
        check_bit("pixels_valid", 1'b0, pixels_valid);
        check_bit("pixels_last", 1'b0, pixels_last);
        check_bit("save_result_valid", 1'b0, save_result_valid);
        check_bit("accum_valid", 1'b0, accum_valid);
        check_bit("cache_blk_sel", 1'b0, cache_blk_sel);
        check_word("channel_sel", '0, channel_sel);
        wait (reset == 1'b0);
        @(posedge clk);
        #1;
        test_header_decode();
        test_weights();
        test_pixel_gaps();
        test_padding();
        test_job_save();
        test_job_no_save();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/conv_stream.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_stream_config.svh"

module conv_stream (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  conv_stream_pkg::stream_word_u      r_data,
    input  wire logic                          r_valid,
    input  wire logic                          r_last,
    output logic                               r_ready,
    output conv_stream_pkg::layer_cfg_t        layer_cfg,
    output conv_stream_pkg::geometry_t         geometry,
    output conv_stream_pkg::norm_params_t      norm_params,
    output logic [`CS_WORD_WIDTH-1:0]          weights,
    output logic [`CS_OUTPUT_DIM-1:0]          channel_sel,
    output logic [`CS_WORD_WIDTH-1:0]          pixels,
    output logic                               pixels_valid,
    output logic                               pixels_last,
    input  wire logic                          cache_wrt_done,
    output logic                               save_result_valid,
    input  wire logic                          save_result_ack,
    output logic                               cache_blk_sel,
    output logic                               accum_valid
);

    logic weight_beat;
    logic weights_done;
    logic pixel_beat;
    logic pixel_end;
    logic emit_done;

    stream_sequencer i_stream_sequencer (
        .clk               (clk),
        .reset             (reset),
        .r_data            (r_data),
        .r_valid           (r_valid),
        .r_last            (r_last),
        .r_ready           (r_ready),
        .weights_done      (weights_done),
        .emit_done         (emit_done),
        .cache_wrt_done    (cache_wrt_done),
        .save_result_ack   (save_result_ack),
        .layer_cfg         (layer_cfg),
        .norm_params       (norm_params),
        .weight_beat       (weight_beat),
        .pixel_beat        (pixel_beat),
        .pixel_end         (pixel_end),
        .save_result_valid (save_result_valid),
        .cache_blk_sel     (cache_blk_sel),
        .accum_valid       (accum_valid)
    );

    layer_geometry i_layer_geometry (
        .clk       (clk),
        .reset     (reset),
        .layer_cfg (layer_cfg),
        .geometry  (geometry)
    );

    weight_distributor i_weight_distributor (
        .clk          (clk),
        .reset        (reset),
        .r_data       (r_data),
        .weight_beat  (weight_beat),
        .kernel_dim   (geometry.kernel_dim),
        .weights      (weights),
        .channel_sel  (channel_sel),
        .weights_done (weights_done)
    );

    pixel_emitter i_pixel_emitter (
        .clk          (clk),
        .reset        (reset),
        .r_data       (r_data),
        .pixel_beat   (pixel_beat),
        .pixel_end    (pixel_end),
        .layer_cfg    (layer_cfg),
        .pixels       (pixels),
        .pixels_valid (pixels_valid),
        .pixels_last  (pixels_last),
        .emit_done    (emit_done)
    );

endmodule

`default_nettype wire

//--- verilog/pixel_emitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_stream_config.svh"

module pixel_emitter (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  conv_stream_pkg::stream_word_u  r_data,
    input  wire logic                      pixel_beat,
    input  wire logic                      pixel_end,
    input  conv_stream_pkg::layer_cfg_t    layer_cfg,
    output logic [`CS_WORD_WIDTH-1:0]      pixels,
    output logic                           pixels_valid,
    output logic                           pixels_last,
    output logic                           emit_done
);

    // bottom row needs cols pixels, right column one more
    logic [`CS_DIM_WIDTH:0] pad_total;
    logic [`CS_DIM_WIDTH:0] pad_left;
    logic                   padding;

    always_comb begin
        pad_total = '0;
        if (layer_cfg.pad_mask[1]) begin
            pad_total = {1'b0, layer_cfg.cols};
        end
        if (layer_cfg.pad_mask[3]) begin
            pad_total = pad_total + 1'b1;
        end
    end

    assign padding = (pad_left != '0);

    // --------------------
    // pixel data
    // --------------------
    always_ff @(posedge clk) begin
        if (padding) begin
            pixels <= '0;
        end else if (pixel_beat) begin
            pixels <= r_data.data;
        end
    end

    // --------------------
    // valid, last and padding count
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pixels_valid <= 1'b0;
            pixels_last  <= 1'b0;
            emit_done    <= 1'b0;
            pad_left     <= '0;
        end else begin
            // one cycle behind the final emitted pixel
            emit_done <= pixels_valid && pixels_last;
            if (padding) begin
                pixels_valid <= 1'b1;
                pixels_last  <= (pad_left == 1);
                pad_left     <= pad_left - 1'b1;
            end else if (pixel_beat) begin
                pixels_valid <= 1'b1;
                // last real pixel closes the job only without padding
                pixels_last  <= pixel_end && (pad_total == '0);
                if (pixel_end) begin
                    pad_left <= pad_total;
                end
            end else begin
                pixels_valid <= 1'b0;
                pixels_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/weight_distributor.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_stream_config.svh"

module weight_distributor (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  conv_stream_pkg::stream_word_u  r_data,
    input  wire logic                      weight_beat,
    input  wire logic [`CS_KDIM_WIDTH-1:0] kernel_dim,
    output logic [`CS_WORD_WIDTH-1:0]      weights,
    output logic [`CS_OUTPUT_DIM-1:0]      channel_sel,
    output logic                           weights_done
);

    logic [`CS_KDIM_WIDTH-1:0] kernel_cnt;
    logic [`CS_CHAN_WIDTH-1:0] chan_cnt;
    // channel of the word now on weights
    logic [`CS_CHAN_WIDTH-1:0] sel_chan;
    logic                      sel_valid;
    logic                      kernel_last;
    logic                      chan_last;

    assign kernel_last  = (kernel_cnt == kernel_dim - 1'b1);
    assign chan_last    = (chan_cnt == `CS_CHAN_WIDTH'(`CS_OUTPUT_DIM - 1));
    assign weights_done = weight_beat && kernel_last && chan_last;

    always_ff @(posedge clk) begin
        if (weight_beat) begin
            weights <= r_data.data;
        end
    end

    // --------------------
    // kernel and channel counters
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            kernel_cnt <= '0;
            chan_cnt   <= '0;
            sel_chan   <= '0;
            sel_valid  <= 1'b0;
        end else begin
            sel_valid <= weight_beat;
            if (weight_beat) begin
                sel_chan <= chan_cnt;
                if (kernel_last) begin
                    kernel_cnt <= '0;
                    // wraps to zero once the last channel is filled
                    chan_cnt   <= chan_last ? '0 : chan_cnt + 1'b1;
                end else begin
                    kernel_cnt <= kernel_cnt + 1'b1;
                end
            end
        end
    end

    // one-hot select, only alongside a fresh weight word
    always_comb begin
        channel_sel = '0;
        for (int i = 0; i < `CS_OUTPUT_DIM; i++) begin
            if (sel_valid && (sel_chan == i)) begin
                channel_sel[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/layer_geometry.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_stream_config.svh"

module layer_geometry (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  conv_stream_pkg::layer_cfg_t    layer_cfg,
    output conv_stream_pkg::geometry_t     geometry
);

    logic [`CS_DIM_WIDTH-1:0]  padded_cols;
    logic [`CS_DIM_WIDTH-1:0]  padded_rows;
    logic [`CS_KDIM_WIDTH-1:0] kernel_dim;

    // decoded straight from the config so the first weight beat sees it
    always_comb begin
        case (layer_cfg.conv_size)
            `CS_CONV_SIZE_1_1: kernel_dim = `CS_KERNEL_DIM_1_1;
            `CS_CONV_SIZE_3_3: kernel_dim = `CS_KERNEL_DIM_3_3;
            default:           kernel_dim = `CS_KERNEL_DIM_3_3;
        endcase
    end

    assign geometry.kernel_dim = kernel_dim;

    // stage 1 padded image, stage 2 conv result
    always_ff @(posedge clk) begin
        if (reset) begin
            padded_cols          <= '0;
            padded_rows          <= '0;
            geometry.result_cols <= '0;
            geometry.result_rows <= '0;
        end else begin
            padded_cols <= layer_cfg.cols + {{(`CS_DIM_WIDTH-1){1'b0}}, layer_cfg.pad_mask[2]}
                                          + {{(`CS_DIM_WIDTH-1){1'b0}}, layer_cfg.pad_mask[3]};
            padded_rows <= layer_cfg.rows + {{(`CS_DIM_WIDTH-1){1'b0}}, layer_cfg.pad_mask[0]}
                                          + {{(`CS_DIM_WIDTH-1){1'b0}}, layer_cfg.pad_mask[1]};
            if (kernel_dim == `CS_KERNEL_DIM_1_1) begin
                geometry.result_cols <= padded_cols;
                geometry.result_rows <= padded_rows;
            end else begin
                geometry.result_cols <= padded_cols - 2'd2;
                geometry.result_rows <= padded_rows - 2'd2;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/stream_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_sequencer (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  conv_stream_pkg::stream_word_u      r_data,
    input  wire logic                          r_valid,
    input  wire logic                          r_last,
    output logic                               r_ready,
    input  wire logic                          weights_done,
    input  wire logic                          emit_done,
    input  wire logic                          cache_wrt_done,
    input  wire logic                          save_result_ack,
    output conv_stream_pkg::layer_cfg_t        layer_cfg,
    output conv_stream_pkg::norm_params_t      norm_params,
    output logic                               weight_beat,
    output logic                               pixel_beat,
    output logic                               pixel_end,
    output logic                               save_result_valid,
    output logic                               cache_blk_sel,
    output logic                               accum_valid
);

    typedef enum logic [2:0] {
        S_HEADER,
        S_NORM_A,
        S_NORM_B,
        S_WEIGHTS,
        S_PIXELS,
        S_PAD_WAIT,
        S_CACHE_WAIT,
        S_SAVE_WAIT
    } state_t;

    state_t state;
    logic   accept;
    // save request of the running job
    logic   save_flag;

    // --------------------
    // beat strobes
    // --------------------
    assign accept      = r_valid && r_ready;
    assign weight_beat = accept && (state == S_WEIGHTS);
    assign pixel_beat  = accept && (state == S_PIXELS);
    assign pixel_end   = pixel_beat && r_last;

    // --------------------
    // job FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= S_HEADER;
            r_ready           <= 1'b0;
            save_flag         <= 1'b0;
            save_result_valid <= 1'b0;
            cache_blk_sel     <= 1'b0;
            accum_valid       <= 1'b0;
            layer_cfg         <= '0;
        end else begin
            case (state)
                S_HEADER: begin
                    r_ready <= 1'b1;
                    if (accept) begin
                        layer_cfg.cols          <= r_data.header.cols;
                        layer_cfg.rows          <= r_data.header.rows;
                        layer_cfg.conv_size     <= r_data.header.conv_size;
                        layer_cfg.pool_stride   <= r_data.header.pool_stride;
                        layer_cfg.pad_mask      <= r_data.header.pad_mask;
                        layer_cfg.activation_en <= r_data.header.activation_en;
                        save_flag               <= r_data.header.save_result;
                        // norm words only travel with a save request
                        if (r_data.header.save_result) begin
                            state <= S_NORM_A;
                        end else begin
                            state <= S_WEIGHTS;
                        end
                    end
                end
                S_NORM_A: begin
                    if (accept) begin
                        state <= S_NORM_B;
                    end
                end
                S_NORM_B: begin
                    if (accept) begin
                        state <= S_WEIGHTS;
                    end
                end
                S_WEIGHTS: begin
                    // distributor flags the final weight of the last channel
                    if (weights_done) begin
                        state <= S_PIXELS;
                    end
                end
                S_PIXELS: begin
                    if (pixel_end) begin
                        r_ready <= 1'b0;
                        state   <= S_PAD_WAIT;
                    end
                end
                S_PAD_WAIT: begin
                    if (emit_done) begin
                        state <= S_CACHE_WAIT;
                    end
                end
                S_CACHE_WAIT: begin
                    if (cache_wrt_done) begin
                        if (save_flag) begin
                            // hand the written block over to the result path
                            cache_blk_sel     <= ~cache_blk_sel;
                            save_result_valid <= 1'b1;
                            accum_valid       <= 1'b0;
                            state             <= S_SAVE_WAIT;
                        end else begin
                            accum_valid <= 1'b1;
                            r_ready     <= 1'b1;
                            state       <= S_HEADER;
                        end
                    end
                end
                S_SAVE_WAIT: begin
                    if (save_result_ack) begin
                        save_result_valid <= 1'b0;
                        save_flag         <= 1'b0;
                        r_ready           <= 1'b1;
                        state             <= S_HEADER;
                    end
                end
                default: begin
                    state <= S_HEADER;
                end
            endcase
        end
    end

    // norm words, a then b
    always_ff @(posedge clk) begin
        if (accept && (state == S_NORM_A)) begin
            norm_params.norm_a <= r_data.data;
        end
        if (accept && (state == S_NORM_B)) begin
            norm_params.norm_b <= r_data.data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_stream_pkg.sv
`default_nettype none

`include "conv_stream_config.svh"

package conv_stream_pkg;

    // --------------------
    // header word layout
    // --------------------
    // low bits first in the stream, msb field first here
    typedef struct packed {
        logic [`CS_WORD_WIDTH-`CS_HDR_USED_BITS-1:0] reserved;
        logic                                         activation_en;
        logic                                         save_result;
        // right, left, bottom, top
        logic [`CS_PAD_WIDTH-1:0]                     pad_mask;
        logic [`CS_STRIDE_WIDTH-1:0]                  pool_stride;
        logic [`CS_CONV_SIZE_WIDTH-1:0]               conv_size;
        logic [`CS_DIM_WIDTH-1:0]                     rows;
        logic [`CS_DIM_WIDTH-1:0]                     cols;
    } header_t;

    // one stream beat, raw lanes or a decoded header
    typedef union packed {
        logic [`CS_WORD_WIDTH-1:0] data;
        header_t                   header;
    } stream_word_u;

    // --------------------
    // layer configuration
    // --------------------
    typedef struct packed {
        logic [`CS_DIM_WIDTH-1:0]       cols;
        logic [`CS_DIM_WIDTH-1:0]       rows;
        logic [`CS_CONV_SIZE_WIDTH-1:0] conv_size;
        logic [`CS_STRIDE_WIDTH-1:0]    pool_stride;
        logic [`CS_PAD_WIDTH-1:0]       pad_mask;
        logic                           activation_en;
    } layer_cfg_t;

    // kernel size and conv output size
    typedef struct packed {
        logic [`CS_KDIM_WIDTH-1:0] kernel_dim;
        logic [`CS_DIM_WIDTH-1:0]  result_cols;
        logic [`CS_DIM_WIDTH-1:0]  result_rows;
    } geometry_t;

    // one lane per output channel
    typedef struct packed {
        logic [`CS_OUTPUT_DIM*`CS_DATA_WIDTH-1:0] norm_a;
        logic [`CS_OUTPUT_DIM*`CS_DATA_WIDTH-1:0] norm_b;
    } norm_params_t;

endpackage

`default_nettype wire

//--- verilog/conv_stream_config.svh
`ifndef CONV_STREAM_CONFIG_SVH
`define CONV_STREAM_CONFIG_SVH

// --------------------
// stream word geometry
// --------------------
`define CS_DATA_WIDTH       16
`define CS_INPUT_DIM        4
`define CS_WORD_WIDTH       (`CS_INPUT_DIM * `CS_DATA_WIDTH)
`define CS_OUTPUT_DIM       4
`define CS_CHAN_WIDTH       2

// image dimensions
`define CS_DIM_WIDTH        9

// --------------------
// header field widths
// --------------------
`define CS_CONV_SIZE_WIDTH  2
`define CS_STRIDE_WIDTH     2
`define CS_PAD_WIDTH        4
// cols, rows, conv size, stride, pad mask, save, activation
`define CS_HDR_USED_BITS    28

// conv size codes and weights per channel
`define CS_CONV_SIZE_1_1    2'd0
`define CS_CONV_SIZE_3_3    2'd1
`define CS_KDIM_WIDTH       4
`define CS_KERNEL_DIM_1_1   4'd1
`define CS_KERNEL_DIM_3_3   4'd9

`endif
